// ==== include/rvc_opcodes.svh ====
// RVC match patterns for the GPR decoder
// each macro is a casez pattern over the low 16 bits of an instruction
`ifndef RVC_OPCODES_SVH
`define RVC_OPCODES_SVH

// quadrant 0
`define C_ADDI4SPN 16'b000_????????_???_00
`define C_LW       16'b010_???_???_??_???_00
`define C_SW       16'b110_???_???_??_???_00

// quadrant 1
// C_NOP must be matched before C_ADDI, C_ADDI16SP before C_LUI
`define C_NOP      16'b000_?_00000_?????_01
`define C_ADDI     16'b000_?_?????_?????_01
`define C_JAL      16'b001_???????????_01
`define C_LI       16'b010_?_?????_?????_01
`define C_ADDI16SP 16'b011_?_00010_?????_01
`define C_LUI      16'b011_?_?????_?????_01
`define C_SRLI     16'b100_?_00_???_?????_01
`define C_SRAI     16'b100_?_01_???_?????_01
`define C_ANDI     16'b100_?_10_???_?????_01
`define C_SUB      16'b100_0_11_???_00_???_01
`define C_XOR      16'b100_0_11_???_01_???_01
`define C_OR       16'b100_0_11_???_10_???_01
`define C_AND      16'b100_0_11_???_11_???_01
`define C_J        16'b101_???????????_01
`define C_BEQZ     16'b110_???_???_?????_01
`define C_BNEZ     16'b111_???_???_?????_01

// quadrant 2
// JR before MV, EBREAK before JALR, JALR before ADD
`define C_SLLI     16'b000_?_?????_?????_10
`define C_LWSP     16'b010_?_?????_?????_10
`define C_JR       16'b100_0_?????_00000_10
`define C_MV       16'b100_0_?????_?????_10
`define C_EBREAK   16'b100_1_00000_00000_10
`define C_JALR     16'b100_1_?????_00000_10
`define C_ADD      16'b100_1_?????_?????_10
`define C_SWSP     16'b110_??????_?????_10

`endif

// ==== run.sh ====
#!/usr/bin/env bash
# build the decode stage testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 -f sim.f --top-module tb_decode_stage \
  -o tb_decode_stage
result=$(./obj_dir/tb_decode_stage +verilator+error+limit+1000)
echo "$result"
grep -qx "Test completed successfully" <<< "$result"

// ==== sim.f ====
+incdir+include
source/rv_isa_pkg.sv
source/decode_flow_pkg.sv
source/instr_align.sv
source/riscv_decoder_gpr.sv
source/gpr_file.sv
source/decode_stage.sv
sim/tb_decode_model.sv
sim/decode_stage_chk.sv
sim/tb_decode_stage.sv

// ==== sim/decode_stage_chk.sv ====
// decode stage checker
// credit accounting on both sides and quiet outputs after reset
`timescale 1ns/1ps

module decode_stage_chk (
  input logic                     clk,
  input logic                     rst_n,
  input logic                     fetch_valid,
  input logic                     fetch_credit,
  input logic                     out_credit,
  input logic                     out_valid,
  input decode_flow_pkg::credit_t credit_q
);
  import decode_flow_pkg::*;

  credit_t up_cred;    // credits held by upstream
  credit_t down_cred;  // downstream credits seen at the ports
  int      fail_count = 0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      up_cred   <= credit_t'(fetch_credits);
      down_cred <= credit_t'(out_credits);
    end else begin
      up_cred   <= up_cred + credit_t'(fetch_credit) - credit_t'(fetch_valid);
      down_cred <= down_cred + credit_t'(out_credit) - credit_t'(out_valid);
    end
  end

  fetch_has_credit: assert property (@(posedge clk) disable iff (!rst_n)
    fetch_valid |-> (up_cred != '0))
    else begin
      $error("fetch word sent with no credit held");
      fail_count++;
    end

  out_credit_range: assert property (@(posedge clk) disable iff (!rst_n)
    credit_q <= credit_t'(out_credits))
    else begin
      $error("downstream credit count out of range");
      fail_count++;
    end

  issue_has_credit: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid |-> (down_cred != '0))
    else begin
      $error("output issued at zero credits");
      fail_count++;
    end

  quiet_at_release: assert property (@(posedge clk)
    $rose(rst_n) |-> (!out_valid && !fetch_credit))
    else begin
      $error("outputs active right after reset");
      fail_count++;
    end

  quiet_after_release: assert property (@(posedge clk)
    $rose(rst_n) |=> (!out_valid && !fetch_credit))
    else begin
      $error("outputs active one cycle after reset");
      fail_count++;
    end

endmodule

bind decode_stage decode_stage_chk chk0 (
  .clk          (clk),
  .rst_n        (rst_n),
  .fetch_valid  (fetch_valid),
  .fetch_credit (fetch_credit),
  .out_credit   (out_credit),
  .out_valid    (out_valid),
  .credit_q     (credit_q)
);

// ==== sim/tb_decode_model.sv ====
// reference model for the decode stage
// expected instruction stream, GPR address decode and shadow register values
`timescale 1ns/1ps
`include "rvc_opcodes.svh"

module tb_decode_model;
  import rv_isa_pkg::*;

  instr_t exp_q [$];  // generated stream, oldest first
  xlen_t  shadow [num_gprs] = '{default: '0};

  function automatic void push_instr(instr_t i);
    exp_q.push_back(i);
  endfunction

  function automatic int count();
    return exp_q.size();
  endfunction

  function automatic instr_t expected(int n);
    return exp_q[n];
  endfunction

  function automatic void write_reg(reg_addr_t addr, xlen_t data);
    if (addr != reg_x0) begin
      shadow[addr] = data;
    end
  endfunction

  function automatic xlen_t read_reg(reg_addr_t addr);
    return (addr == reg_x0) ? '0 : shadow[addr];
  endfunction

  // x0 wherever a form names no register
  function automatic void decode_gpr(input instr_t i, output reg_addr_t rd,
                                     output reg_addr_t rs1, output reg_addr_t rs2);
    half_t     h;
    reg_addr_t f_hi;
    reg_addr_t f_lo;
    reg_addr_t p_hi;
    reg_addr_t p_lo;
    h    = i[15:0];
    f_hi = h[11:7];
    f_lo = h[6:2];
    p_hi = 5'd8 + {2'b00, h[9:7]};  // x8..x15
    p_lo = 5'd8 + {2'b00, h[4:2]};
    rd   = reg_x0;
    rs1  = reg_x0;
    rs2  = reg_x0;
    if (i[1:0] == 2'b11) begin
      rd  = i[11:7];
      rs1 = i[19:15];
      rs2 = i[24:20];
    end else begin
      casez (h)
        `C_NOP, `C_J, `C_EBREAK: begin
        end
        `C_ADDI4SPN: {rd, rs1} = {p_lo, reg_sp};
        `C_LW: {rd, rs1} = {p_lo, p_hi};
        `C_SW: {rs1, rs2} = {p_hi, p_lo};
        `C_ADDI16SP: {rd, rs1} = {reg_sp, reg_sp};
        `C_ADDI, `C_SLLI: {rd, rs1} = {f_hi, f_hi};
        `C_JAL: rd = reg_ra;
        `C_LI, `C_LUI: rd = f_hi;
        `C_SRLI, `C_SRAI, `C_ANDI: {rd, rs1} = {p_hi, p_hi};
        `C_SUB, `C_XOR, `C_OR, `C_AND: {rd, rs1, rs2} = {p_hi, p_hi, p_lo};
        `C_BEQZ, `C_BNEZ: rs1 = p_hi;
        `C_LWSP: {rd, rs1} = {f_hi, reg_sp};
        `C_JR: rs1 = f_hi;
        `C_MV: {rd, rs2} = {f_hi, f_lo};
        `C_JALR: {rd, rs1} = {reg_ra, f_hi};
        `C_ADD: {rd, rs1, rs2} = {f_hi, f_hi, f_lo};
        `C_SWSP: {rs1, rs2} = {reg_sp, f_lo};
        default: begin
        end
      endcase
    end
  endfunction

endmodule

// ==== sim/tb_decode_stage.sv ====
// testbench for the RV32IC decode stage
// random instruction stream with credits on both sides, checked against tb_decode_model
`timescale 1ns/1ps

module tb_decode_stage;
  import rv_isa_pkg::*;
  import decode_flow_pkg::*;

  localparam int num_instr    = 400;
  localparam int reset_cycles = 10;
  localparam int max_cycles   = num_instr * 8 + reset_cycles;
  localparam int num_forms    = 21;

  // compressed forms as fixed bits over a random halfword
  localparam half_t form_mask [num_forms] = '{
    16'hE003, 16'hE003, 16'hE003, 16'hEF83, 16'hE003, 16'hE003, 16'hE003,
    16'hEF83, 16'hE003, 16'hE003, 16'hEC03, 16'hE003, 16'hE003, 16'hE003,
    16'hE003, 16'hE003, 16'hF07F, 16'hF07F, 16'hFFFF, 16'hE003, 16'hE003
  };
  localparam half_t form_val [num_forms] = '{
    16'h0000, 16'h4000, 16'hC000, 16'h0001, 16'h0001, 16'h2001, 16'h4001,
    16'h6101, 16'h6001, 16'h8001, 16'h8C01, 16'hA001, 16'hC001, 16'hE001,
    16'h0002, 16'h4002, 16'h8002, 16'h9002, 16'h9002, 16'h8002, 16'hC002
  };

  logic        clk = 1'b0;
  logic        rst_n;
  logic        fetch_valid = 1'b0;
  instr_t      fetch_word = '0;
  logic        fetch_credit;
  logic        out_credit = 1'b0;
  logic        out_valid;
  instr_t      out_instr;
  logic        out_compressed;
  reg_addr_t   out_rd;
  reg_addr_t   out_rs1;
  reg_addr_t   out_rs2;
  xlen_t       out_rs1_data;
  xlen_t       out_rs2_data;
  logic        wb_en = 1'b0;
  reg_addr_t   wb_addr = '0;
  xlen_t       wb_data = '0;

  logic [31:0] lcg_state = 32'd42065;
  instr_t      words [$];
  int          cycles = 0;
  int          next_word = 0;  // words sent upstream
  int          returned = 0;   // out_credit pulses
  int          out_seen = 0;
  int          fetch_pulses = 0;
  int          value_errors = 0;
  int          other_errors = 0;
  int          end_errors = 0;
  int          chk_errors;

  decode_stage dut0 (
    .clk            (clk),
    .rst_n          (rst_n),
    .fetch_valid    (fetch_valid),
    .fetch_word     (fetch_word),
    .fetch_credit   (fetch_credit),
    .out_credit     (out_credit),
    .out_valid      (out_valid),
    .out_instr      (out_instr),
    .out_compressed (out_compressed),
    .out_rd         (out_rd),
    .out_rs1        (out_rs1),
    .out_rs2        (out_rs2),
    .out_rs1_data   (out_rs1_data),
    .out_rs2_data   (out_rs2_data),
    .wb_en          (wb_en),
    .wb_addr        (wb_addr),
    .wb_data        (wb_data)
  );

  tb_decode_model model0 ();

  always #5 clk = ~clk;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic int rand_below(int n);
    return int'(lcg_next() >> 16) % n;  // upper bits, low ones cycle fast
  endfunction

  task automatic build_stream();
    half_t  halves [$];
    half_t  h;
    instr_t w;
    int     k;
    logic   comp;
    for (int n = 0; n < num_instr; n++) begin
      if (n == num_instr - 1) begin
        comp = (halves.size() % 2) == 1;  // last one fills the final word
      end else begin
        comp = rand_below(2) == 0;
      end
      if (comp) begin
        k = rand_below(num_forms);
        h = (half_t'(lcg_next() >> 8) & ~form_mask[k]) | form_val[k];
        halves.push_back(h);
        model0.push_instr({16'h0000, h});
      end else begin
        w = lcg_next() | 32'h3;
        halves.push_back(w[15:0]);
        halves.push_back(w[31:16]);
        model0.push_instr(w);
      end
    end
    for (int j = 0; j < halves.size(); j += 2) begin
      words.push_back({halves[j + 1], halves[j]});
    end
  endtask

  task automatic check_instr(input string name, input instr_t got, input instr_t want);
    if (got !== want) begin
      $display("MISMATCH %0t %s got %h expected %h", $time, name, got, want);
      value_errors++;
    end
  endtask

  task automatic check_addr(input string name, input reg_addr_t got, input reg_addr_t want);
    if (got !== want) begin
      $display("MISMATCH %0t %s got %0d expected %0d", $time, name, got, want);
      value_errors++;
    end
  endtask

  task automatic check_data(input string name, input xlen_t got, input xlen_t want);
    if (got !== want) begin
      $display("MISMATCH %0t %s got %h expected %h", $time, name, got, want);
      value_errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic want);
    if (got !== want) begin
      $display("MISMATCH %0t %s got %b expected %b", $time, name, got, want);
      value_errors++;
    end
  endtask

  always @(posedge clk) begin
    if (cycles == 0) begin
      build_stream();
    end
    cycles++;
    if (wb_en) begin
      model0.write_reg(wb_addr, wb_data);  // commits at this edge
    end
    fetch_valid <= 1'b0;
    out_credit  <= 1'b0;
    wb_en       <= 1'b0;
    if (rst_n) begin
      if (fetch_credits + fetch_pulses - next_word > 0 && next_word < words.size() &&
          rand_below(4) != 0) begin
        fetch_valid <= 1'b1;
        fetch_word  <= words[next_word];
        next_word++;
      end
      // credits held back for 64 cycles out of every 192
      if (out_seen - returned > 0 && (cycles / 64) % 3 != 2 && rand_below(3) != 0) begin
        out_credit <= 1'b1;
        returned++;
      end
      if (rand_below(2) == 0) begin
        wb_en   <= 1'b1;
        wb_addr <= reg_addr_t'(rand_below(num_gprs));
        wb_data <= lcg_next();
      end
    end
  end

  always @(negedge clk) begin
    instr_t    exp_i;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    if (fetch_credit) begin
      fetch_pulses++;
    end
    if (out_valid) begin
      if (out_seen >= model0.count()) begin
        $display("extra instruction came out at %0t", $time);
        other_errors++;
      end else begin
        exp_i = model0.expected(out_seen);
        model0.decode_gpr(exp_i, rd, rs1, rs2);
        check_instr("out_instr", out_instr, exp_i);
        check_bit("out_compressed", out_compressed, exp_i[1:0] != 2'b11);
        check_addr("out_rd", out_rd, rd);
        check_addr("out_rs1", out_rs1, rs1);
        check_addr("out_rs2", out_rs2, rs2);
        check_data("out_rs1_data", out_rs1_data, model0.read_reg(rs1));
        check_data("out_rs2_data", out_rs2_data, model0.read_reg(rs2));
      end
      out_seen++;
      if (out_seen > out_credits + returned) begin
        $display("more outputs than downstream credits at %0t", $time);
        other_errors++;
      end
    end
  end

  initial begin
    rst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    rst_n <= 1'b1;
    wait (out_seen >= num_instr || cycles >= max_cycles);
    if (out_seen < num_instr) begin
      $display("timeout after %0d cycles, %0d of %0d instructions came out",
               cycles, out_seen, num_instr);
      end_errors++;
    end
    repeat (4) @(posedge clk);
    if (next_word != words.size() || fetch_pulses != next_word) begin
      $display("fetch credits returned %0d for %0d words sent of %0d",
               fetch_pulses, next_word, words.size());
      end_errors++;
    end
    chk_errors = dut0.chk0.fail_count;
    $display("errors: %0d mismatch, %0d flow, %0d end of run, %0d assertion",
             value_errors, other_errors, end_errors, chk_errors);
    if (value_errors + other_errors + end_errors + chk_errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== source/decode_flow_pkg.sv ====
// flow control sizes for the decode stage
// fetch side and downstream side both run on credits
package decode_flow_pkg;

  // fetch buffer depth, also the credits upstream holds after reset
  localparam int fetch_credits = 2;

  // credits the stage may spend downstream after reset
  localparam int out_credits = 4;

  // must hold out_credits without wrapping
  typedef logic [2:0] credit_t;

endpackage

// ==== source/decode_stage.sv ====
// RV32IC decode stage, register address part
// aligns fetch words, decodes GPR addresses, reads operands, issues on credits
`timescale 1ns/1ps

module decode_stage (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  fetch_valid,
  input  rv_isa_pkg::instr_t    fetch_word,
  output logic                  fetch_credit,
  input  logic                  out_credit,
  output logic                  out_valid,
  output rv_isa_pkg::instr_t    out_instr,
  output logic                  out_compressed,
  output rv_isa_pkg::reg_addr_t out_rd,
  output rv_isa_pkg::reg_addr_t out_rs1,
  output rv_isa_pkg::reg_addr_t out_rs2,
  output rv_isa_pkg::xlen_t     out_rs1_data,
  output rv_isa_pkg::xlen_t     out_rs2_data,
  input  logic                  wb_en,
  input  rv_isa_pkg::reg_addr_t wb_addr,
  input  rv_isa_pkg::xlen_t     wb_data
);
  import rv_isa_pkg::*;
  import decode_flow_pkg::*;

  logic      al_valid;
  logic      al_issue;
  logic      al_compressed;
  instr_t    al_instr;
  reg_addr_t dec_rd;
  reg_addr_t dec_rs1;
  reg_addr_t dec_rs2;
  xlen_t     rs1_data;
  xlen_t     rs2_data;
  credit_t   credit_q;

  instr_align align0 (
    .clk           (clk),
    .rst_n         (rst_n),
    .fetch_valid   (fetch_valid),
    .fetch_word    (fetch_word),
    .al_issue      (al_issue),
    .fetch_credit  (fetch_credit),
    .al_valid      (al_valid),
    .al_instr      (al_instr),
    .al_compressed (al_compressed)
  );

  riscv_decoder_gpr gpr_dec0 (
    .instr      (al_instr),
    .compressed (al_compressed),
    .rd_addr    (dec_rd),
    .rs1_addr   (dec_rs1),
    .rs2_addr   (dec_rs2)
  );

  gpr_file gpr0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .rs1_addr (dec_rs1),
    .rs2_addr (dec_rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wb_en    (wb_en),
    .wb_addr  (wb_addr),
    .wb_data  (wb_data)
  );

  assign al_issue = al_valid && (credit_q != '0);

  // taken at issue, so the count already covers the out_valid of the next cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      credit_q  <= credit_t'(out_credits);
      out_valid <= 1'b0;
    end else begin
      credit_q  <= credit_q + credit_t'(out_credit) - credit_t'(al_issue);
      out_valid <= al_issue;  // one cycle per issue
    end
  end

  always_ff @(posedge clk) begin
    if (al_issue) begin
      out_instr      <= al_instr;
      out_compressed <= al_compressed;
      out_rd         <= dec_rd;
      out_rs1        <= dec_rs1;
      out_rs2        <= dec_rs2;
      out_rs1_data   <= rs1_data;
      out_rs2_data   <= rs2_data;
    end
  end

endmodule

// ==== source/gpr_file.sv ====
// 32 x 32 integer register file
// two read ports with write bypass, one write port, x0 reads as zero
`timescale 1ns/1ps

module gpr_file (
  input  logic                  clk,
  input  logic                  rst_n,
  input  rv_isa_pkg::reg_addr_t rs1_addr,
  input  rv_isa_pkg::reg_addr_t rs2_addr,
  output rv_isa_pkg::xlen_t     rs1_data,
  output rv_isa_pkg::xlen_t     rs2_data,
  input  logic                  wb_en,
  input  rv_isa_pkg::reg_addr_t wb_addr,
  input  rv_isa_pkg::xlen_t     wb_data
);
  import rv_isa_pkg::*;

  xlen_t regs_q [num_gprs];
  logic  wr_ok;

  assign wr_ok = wb_en && (wb_addr != reg_x0);  // entry 0 never written

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int r = 0; r < num_gprs; r++) begin
        regs_q[r] <= '0;
      end
    end else if (wr_ok) begin
      regs_q[wb_addr] <= wb_data;
    end
  end

  // same-cycle write wins over the stored value
  assign rs1_data = (wr_ok && (wb_addr == rs1_addr)) ? wb_data : regs_q[rs1_addr];
  assign rs2_data = (wr_ok && (wb_addr == rs2_addr)) ? wb_data : regs_q[rs2_addr];

endmodule

// ==== source/instr_align.sv ====
// instruction aligner for RV32IC fetch words
// splits a two-word buffer into 16/32-bit instructions, returns a credit per freed word
`timescale 1ns/1ps

module instr_align (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               fetch_valid,
  input  rv_isa_pkg::instr_t fetch_word,
  input  logic               al_issue,
  output logic               fetch_credit,
  output logic               al_valid,
  output rv_isa_pkg::instr_t al_instr,
  output logic               al_compressed
);
  import rv_isa_pkg::*;
  import decode_flow_pkg::*;

  instr_t     words_q [fetch_credits];
  logic       rd_ptr_q;
  logic       wr_ptr_q;
  logic       nxt_ptr;
  logic [1:0] count_q;
  logic       carry_q;  // next instr starts in upper half of head

  instr_t     head_word;
  instr_t     next_word;
  half_t      first_half;
  logic       is_comp;
  logic       buf_full;
  logic       pop;
  logic       issue_pop;

  assign nxt_ptr   = rd_ptr_q + 1'b1;
  assign head_word = words_q[rd_ptr_q];
  assign next_word = words_q[nxt_ptr];
  assign buf_full  = (count_q == 2'(fetch_credits));

  assign first_half = carry_q ? head_word[31:16] : head_word[15:0];
  assign is_comp    = (first_half[1:0] != 2'b11);

  // a 32-bit instr starting in the upper half needs the next word too
  assign al_valid = (count_q != 2'd0) && (is_comp || !carry_q || buf_full);

  always_comb begin
    if (is_comp) begin
      al_instr = {16'h0000, first_half};
    end else if (carry_q) begin
      al_instr = {next_word[15:0], head_word[31:16]};  // straddles two words
    end else begin
      al_instr = head_word;
    end
  end

  assign al_compressed = is_comp;

  // head word is done unless a 16-bit instr leaves its upper half
  assign pop       = carry_q | ~is_comp;
  assign issue_pop = al_issue && pop;

  always_ff @(posedge clk) begin
    if (fetch_valid) begin
      words_q[wr_ptr_q] <= fetch_word;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr_q     <= 1'b0;
      wr_ptr_q     <= 1'b0;
      count_q      <= 2'd0;
      carry_q      <= 1'b0;
      fetch_credit <= 1'b0;
    end else begin
      fetch_credit <= issue_pop;  // one pulse per freed word
      if (fetch_valid) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (al_issue) begin
        carry_q <= carry_q ^ is_comp;  // advance one or two halfwords
      end
      if (issue_pop) begin
        rd_ptr_q <= nxt_ptr;
      end
      count_q <= count_q + 2'(fetch_valid) - 2'(issue_pop);
    end
  end

endmodule

// ==== source/riscv_decoder_gpr.sv ====
// RV32IC register address decode
// gives rd/rs1/rs2 for full and compressed instructions, implicit registers included
`timescale 1ns/1ps
`include "rvc_opcodes.svh"

module riscv_decoder_gpr (
  input  rv_isa_pkg::instr_t    instr,
  input  logic                  compressed,
  output rv_isa_pkg::reg_addr_t rd_addr,
  output rv_isa_pkg::reg_addr_t rs1_addr,
  output rv_isa_pkg::reg_addr_t rs2_addr
);
  import rv_isa_pkg::*;

  half_t     c_i;
  reg_addr_t c_rd;    // full 5-bit field at 11:7
  reg_addr_t c_rs2;   // full 5-bit field at 6:2
  reg_addr_t c_rs1p;  // x8..x15 from 9:7
  reg_addr_t c_rs2p;  // x8..x15 from 4:2

  assign c_i    = instr[15:0];
  assign c_rd   = c_i[11:7];
  assign c_rs2  = c_i[6:2];
  assign c_rs1p = {2'b01, c_i[9:7]};
  assign c_rs2p = {2'b01, c_i[4:2]};

  always_comb begin
    rd_addr  = instr[11:7];
    rs1_addr = instr[19:15];
    rs2_addr = instr[24:20];
    if (compressed) begin
      // fields a form does not use read as x0
      rd_addr  = reg_x0;
      rs1_addr = reg_x0;
      rs2_addr = reg_x0;
      casez (c_i)
        `C_ADDI4SPN: begin
          rd_addr  = c_rs2p;
          rs1_addr = reg_sp;
        end
        `C_LW: begin
          rd_addr  = c_rs2p;
          rs1_addr = c_rs1p;
        end
        `C_SW: begin
          rs1_addr = c_rs1p;
          rs2_addr = c_rs2p;
        end
        `C_NOP: begin
        end
        `C_ADDI: begin
          rd_addr  = c_rd;
          rs1_addr = c_rd;
        end
        `C_JAL: rd_addr = reg_ra;
        `C_LI: rd_addr = c_rd;  // rs1 is x0
        `C_ADDI16SP: begin
          rd_addr  = reg_sp;
          rs1_addr = reg_sp;
        end
        `C_LUI: rd_addr = c_rd;
        `C_SRLI, `C_SRAI, `C_ANDI: begin
          rd_addr  = c_rs1p;
          rs1_addr = c_rs1p;
        end
        `C_SUB, `C_XOR, `C_OR, `C_AND: begin
          rd_addr  = c_rs1p;
          rs1_addr = c_rs1p;
          rs2_addr = c_rs2p;
        end
        `C_J: begin
        end
        `C_BEQZ, `C_BNEZ: rs1_addr = c_rs1p;  // compared against x0
        `C_SLLI: begin
          rd_addr  = c_rd;
          rs1_addr = c_rd;
        end
        `C_LWSP: begin
          rd_addr  = c_rd;
          rs1_addr = reg_sp;
        end
        `C_JR: rs1_addr = c_rd;
        `C_MV: begin
          rd_addr  = c_rd;
          rs2_addr = c_rs2;
        end
        `C_EBREAK: begin
        end
        `C_JALR: begin
          rd_addr  = reg_ra;
          rs1_addr = c_rd;
        end
        `C_ADD: begin
          rd_addr  = c_rd;
          rs1_addr = c_rd;
          rs2_addr = c_rs2;
        end
        `C_SWSP: begin
          rs1_addr = reg_sp;
          rs2_addr = c_rs2;
        end
        default: begin
        end
      endcase
    end
  end

endmodule

// ==== source/rv_isa_pkg.sv ====
// RV32 ISA types and fixed register numbers
package rv_isa_pkg;

  typedef logic [31:0] instr_t;    // compressed forms sit in 15:0, upper half zero
  typedef logic [15:0] half_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [31:0] xlen_t;

  // implicit registers of the compressed forms
  localparam reg_addr_t reg_x0 = 5'd0;
  localparam reg_addr_t reg_ra = 5'd1;  // link register
  localparam reg_addr_t reg_sp = 5'd2;  // stack pointer

  localparam int num_gprs = 32;

endpackage
